/* common/nn_pkg.sv */
`default_nettype none

package nn_pkg;

    ///////////////////////////////
    // sizes
    ///////////////////////////////

    localparam int NEURON_NUM       = 3;
    localparam int LAYER_NUM        = 4;
    localparam int WEIGHT_CELLS     = NEURON_NUM * NEURON_NUM;

    // cell widths in bits
    localparam int Z_WIDTH          = 10;
    localparam int ACT_WIDTH        = 8;
    localparam int DELTA_WIDTH      = 8;
    localparam int WEIGHT_WIDTH     = 16;
    localparam int LAYER_ADDR_WIDTH = 2;

    // learning rate as a right shift of a*delta
    localparam int LR_SHIFT         = 4;
    // hard sigmoid midpoint
    localparam int SIGMOID_BIAS     = 128;

    // zero-extended activation times signed delta
    localparam int PROD_WIDTH       = ACT_WIDTH + 1 + DELTA_WIDTH;
    // old weight minus shifted product, wide enough to never wrap
    localparam int DIFF_WIDTH       = WEIGHT_WIDTH + 2;

    ///////////////////////////////
    // types
    ///////////////////////////////

    typedef logic [LAYER_ADDR_WIDTH-1:0]          layer_t;
    // cell 0 sits in the low bits of every vector
    typedef logic [NEURON_NUM*Z_WIDTH-1:0]        z_vec_t;
    typedef logic [NEURON_NUM*ACT_WIDTH-1:0]      act_vec_t;
    typedef logic [NEURON_NUM*DELTA_WIDTH-1:0]    delta_vec_t;
    // cell (i, j) at index i*NEURON_NUM + j, i = delta neuron, j = activation neuron
    typedef logic [WEIGHT_CELLS*WEIGHT_WIDTH-1:0] weight_mat_t;

    // backward read response, tagged with its layer
    typedef struct packed {
        layer_t      layer;
        weight_mat_t weights;
    } w_rsp_t;

    // write-back request from the updater
    typedef struct packed {
        layer_t      layer;
        weight_mat_t weights;
    } wr_req_t;

    typedef enum logic {
        BW_IDLE,
        BW_WAIT_WRITE
    } bw_state_t;

endpackage

`default_nettype wire

/* hw/stream_fork.sv */
`timescale 1ns/1ps
`default_nettype none

// one valid/ready source fanned out to BRANCHES consumers
// data bits are wired around the fork by the parent
module stream_fork #(
    parameter int BRANCHES = 2
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                in_valid,
    output logic                in_ready,

    output logic [BRANCHES-1:0] out_valid,
    input  logic [BRANCHES-1:0] out_ready
);

    // branches that already took the current item
    logic [BRANCHES-1:0] taken;
    logic                in_fire;

    // a served branch drops valid until the whole item is done
    assign out_valid = {BRANCHES{in_valid}} & ~taken;

    // every branch is either served or taking it now
    assign in_ready = &(taken | out_ready);
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            taken <= '0;
        end else if (in_fire) begin
            taken <= '0;
        end else begin
            taken <= taken | (out_valid & out_ready);
        end
    end

endmodule

`default_nettype wire

/* hw/activation_path.sv */
`timescale 1ns/1ps
`default_nettype none

// z -> activation, hard sigmoid for hidden layers, truncation for layer 0
module activation_path (
    input  logic              clk,
    input  logic              rst_n,

    input  nn_pkg::z_vec_t    z,
    input  logic              z_valid,
    output logic              z_ready,

    input  nn_pkg::layer_t    sel_layer,
    input  logic              sel_valid,
    output logic              sel_ready,

    output nn_pkg::act_vec_t  a,
    output logic              a_valid,
    input  logic              a_ready,

    output logic              a_overflow
);

    logic             load_ok;
    logic             in_fire;
    logic             bypass;
    nn_pkg::act_vec_t a_next;
    logic             of_next;

    // output register is free or drained this cycle
    assign load_ok   = !a_valid || a_ready;

    // z and select are consumed together
    assign z_ready   = sel_valid && load_ok;
    assign sel_ready = z_valid && load_ok;
    assign in_fire   = z_valid && sel_valid && load_ok;

    // layer 0 sees raw inputs
    assign bypass    = (sel_layer == '0);

    always_comb begin
        logic [nn_pkg::Z_WIDTH-1:0] zc;
        logic signed [nn_pkg::Z_WIDTH:0] sig;

        a_next  = '0;
        of_next = 1'b0;
        for (int j = 0; j < nn_pkg::NEURON_NUM; j++) begin
            zc  = z[j*nn_pkg::Z_WIDTH +: nn_pkg::Z_WIDTH];
            sig = (signed'(zc) >>> 1) + (nn_pkg::Z_WIDTH+1)'(nn_pkg::SIGMOID_BIAS);
            if (bypass) begin
                a_next[j*nn_pkg::ACT_WIDTH +: nn_pkg::ACT_WIDTH] = zc[nn_pkg::ACT_WIDTH-1:0];
                // negative or above the activation range
                of_next = of_next | (|zc[nn_pkg::Z_WIDTH-1:nn_pkg::ACT_WIDTH]);
            end else if (sig[nn_pkg::Z_WIDTH]) begin
                a_next[j*nn_pkg::ACT_WIDTH +: nn_pkg::ACT_WIDTH] = '0;
            end else if (|sig[nn_pkg::Z_WIDTH-1:nn_pkg::ACT_WIDTH]) begin
                a_next[j*nn_pkg::ACT_WIDTH +: nn_pkg::ACT_WIDTH] = '1;
            end else begin
                a_next[j*nn_pkg::ACT_WIDTH +: nn_pkg::ACT_WIDTH] = sig[nn_pkg::ACT_WIDTH-1:0];
            end
        end
    end

    ///////////////////////////////
    // output register
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_valid <= 1'b0;
        end else if (in_fire) begin
            a_valid <= 1'b1;
        end else if (a_ready) begin
            a_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            a          <= a_next;
            a_overflow <= of_next;
        end
    end

endmodule

`default_nettype wire

/* weight_update/weight_store.sv */
`timescale 1ns/1ps
`default_nettype none

// one weight matrix per layer, two registered read ports, one write port
module weight_store (
    input  logic                clk,
    input  logic                rst_n,

    input  nn_pkg::layer_t      bw_layer,
    input  logic                bw_layer_valid,
    output logic                bw_layer_ready,

    output nn_pkg::w_rsp_t      bw_rsp,
    output logic                bw_rsp_valid,
    input  logic                bw_rsp_ready,

    input  nn_pkg::layer_t      fw_layer,
    input  logic                fw_layer_valid,
    output logic                fw_layer_ready,

    output nn_pkg::weight_mat_t fw_data,
    output logic                fw_data_valid,
    input  logic                fw_data_ready,

    input  nn_pkg::wr_req_t     wr,
    input  logic                wr_valid,
    output logic                wr_ready
);

    nn_pkg::weight_mat_t mem [nn_pkg::LAYER_NUM];
    nn_pkg::bw_state_t   bw_state;

    logic bw_fire;
    logic fw_fire;
    logic wr_fire;

    // a second backward read waits until the pending update is written back
    assign bw_layer_ready = (bw_state == nn_pkg::BW_IDLE) && (!bw_rsp_valid || bw_rsp_ready);
    assign fw_layer_ready = !fw_data_valid || fw_data_ready;
    assign wr_ready       = 1'b1;

    assign bw_fire = bw_layer_valid && bw_layer_ready;
    assign fw_fire = fw_layer_valid && fw_layer_ready;
    assign wr_fire = wr_valid && wr_ready;

    ///////////////////////////////
    // storage
    ///////////////////////////////

    // reads in the same edge still see the old row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < nn_pkg::LAYER_NUM; r++) begin
                mem[r] <= '0;
            end
        end else if (wr_fire) begin
            mem[wr.layer] <= wr.weights;
        end
    end

    ///////////////////////////////
    // backward port
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bw_state     <= nn_pkg::BW_IDLE;
            bw_rsp_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bw_state <= nn_pkg::BW_IDLE;
            end else if (bw_fire) begin
                bw_state <= nn_pkg::BW_WAIT_WRITE;
            end
            if (bw_fire) begin
                bw_rsp_valid <= 1'b1;
            end else if (bw_rsp_ready) begin
                bw_rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bw_fire) begin
            bw_rsp.layer   <= bw_layer;
            bw_rsp.weights <= mem[bw_layer];
        end
    end

    ///////////////////////////////
    // forward port
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fw_data_valid <= 1'b0;
        end else if (fw_fire) begin
            fw_data_valid <= 1'b1;
        end else if (fw_data_ready) begin
            fw_data_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fw_fire) begin
            fw_data <= mem[fw_layer];
        end
    end

endmodule

`default_nettype wire

/* weight_update/weight_updater.sv */
`timescale 1ns/1ps
`default_nettype none

// w_new(i, j) = sat(w_old(i, j) - ((a[j] * delta[i]) >>> LR_SHIFT))
module weight_updater (
    input  logic               clk,
    input  logic               rst_n,

    input  nn_pkg::act_vec_t   a,
    input  logic               a_valid,
    output logic               a_ready,

    input  nn_pkg::delta_vec_t delta,
    input  logic               delta_valid,
    output logic               delta_ready,

    input  nn_pkg::w_rsp_t     w_old,
    input  logic               w_old_valid,
    output logic               w_old_ready,

    output nn_pkg::wr_req_t    result,
    output logic               result_valid,
    input  logic               result_ready,

    output logic               saturated
);

    logic                load_ok;
    logic                join_fire;
    nn_pkg::weight_mat_t w_next;
    logic                sat_next;

    assign load_ok = !result_valid || result_ready;

    // three-way join, each ready waits for the other two valids
    assign a_ready     = delta_valid && w_old_valid && load_ok;
    assign delta_ready = a_valid && w_old_valid && load_ok;
    assign w_old_ready = a_valid && delta_valid && load_ok;
    assign join_fire   = a_valid && delta_valid && w_old_valid && load_ok;

    ///////////////////////////////
    // update arithmetic
    ///////////////////////////////

    always_comb begin
        logic signed [nn_pkg::ACT_WIDTH:0]      a_s;
        logic signed [nn_pkg::DELTA_WIDTH-1:0]  d_s;
        logic signed [nn_pkg::WEIGHT_WIDTH-1:0] w_s;
        logic signed [nn_pkg::PROD_WIDTH-1:0]   prod;
        logic signed [nn_pkg::DIFF_WIDTH-1:0]   diff;
        int                                     idx;

        w_next   = '0;
        sat_next = 1'b0;
        for (int i = 0; i < nn_pkg::NEURON_NUM; i++) begin
            for (int j = 0; j < nn_pkg::NEURON_NUM; j++) begin
                idx  = i * nn_pkg::NEURON_NUM + j;
                // activation is unsigned, keep it positive in the product
                a_s  = {1'b0, a[j*nn_pkg::ACT_WIDTH +: nn_pkg::ACT_WIDTH]};
                d_s  = delta[i*nn_pkg::DELTA_WIDTH +: nn_pkg::DELTA_WIDTH];
                w_s  = w_old.weights[idx*nn_pkg::WEIGHT_WIDTH +: nn_pkg::WEIGHT_WIDTH];
                prod = a_s * d_s;
                diff = w_s - (prod >>> nn_pkg::LR_SHIFT);
                // upper bits not a plain sign extension means out of range
                if (diff[nn_pkg::DIFF_WIDTH-1:nn_pkg::WEIGHT_WIDTH-1] !=
                    {(nn_pkg::DIFF_WIDTH-nn_pkg::WEIGHT_WIDTH+1){diff[nn_pkg::DIFF_WIDTH-1]}}) begin
                    w_next[idx*nn_pkg::WEIGHT_WIDTH +: nn_pkg::WEIGHT_WIDTH] =
                        {diff[nn_pkg::DIFF_WIDTH-1],
                         {(nn_pkg::WEIGHT_WIDTH-1){~diff[nn_pkg::DIFF_WIDTH-1]}}};
                    sat_next = 1'b1;
                end else begin
                    w_next[idx*nn_pkg::WEIGHT_WIDTH +: nn_pkg::WEIGHT_WIDTH] =
                        diff[nn_pkg::WEIGHT_WIDTH-1:0];
                end
            end
        end
    end

    ///////////////////////////////
    // result register
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else if (join_fire) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (join_fire) begin
            result.layer   <= w_old.layer;
            result.weights <= w_next;
            saturated      <= sat_next;
        end
    end

endmodule

`default_nettype wire

/* hw/weight_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_controller (
    input  logic                clk,
    input  logic                rst_n,

    // backward pass layer
    input  nn_pkg::layer_t      layer_bw,
    input  logic                layer_bw_valid,
    output logic                layer_bw_ready,
    // forward pass layer
    input  nn_pkg::layer_t      layer_fw,
    input  logic                layer_fw_valid,
    output logic                layer_fw_ready,

    input  nn_pkg::z_vec_t      z,
    input  logic                z_valid,
    output logic                z_ready,

    input  nn_pkg::delta_vec_t  delta,
    input  logic                delta_valid,
    output logic                delta_ready,

    output nn_pkg::weight_mat_t w_fw,
    output logic                w_fw_valid,
    input  logic                w_fw_ready,

    output nn_pkg::weight_mat_t w_bw,
    output logic                w_bw_valid,
    input  logic                w_bw_ready,

    // sticky overflow / saturation flag
    output logic                error
);

    // fork branch 0 feeds the store, branch 1 the activation select
    logic [1:0] layer_valid;
    logic [1:0] layer_ready;
    // fork branch 0 feeds the updater, branch 1 the w_bw output
    logic [1:0] wgt_valid;
    logic [1:0] wgt_ready;

    nn_pkg::w_rsp_t   bw_rsp;
    logic             bw_rsp_valid;
    logic             bw_rsp_ready;

    nn_pkg::act_vec_t a;
    logic             a_valid;
    logic             a_ready;
    logic             a_overflow;

    nn_pkg::wr_req_t  wr;
    logic             wr_valid;
    logic             wr_ready;
    logic             saturated;

    stream_fork #(.BRANCHES(2)) u_layer_fork (
        .clk      (clk           ),
        .rst_n    (rst_n         ),
        .in_valid (layer_bw_valid),
        .in_ready (layer_bw_ready),
        .out_valid(layer_valid   ),
        .out_ready(layer_ready   )
    );

    activation_path u_activation_path (
        .clk       (clk           ),
        .rst_n     (rst_n         ),
        .z         (z             ),
        .z_valid   (z_valid       ),
        .z_ready   (z_ready       ),
        .sel_layer (layer_bw      ),
        .sel_valid (layer_valid[1]),
        .sel_ready (layer_ready[1]),
        .a         (a             ),
        .a_valid   (a_valid       ),
        .a_ready   (a_ready       ),
        .a_overflow(a_overflow    )
    );

    weight_store u_weight_store (
        .clk           (clk           ),
        .rst_n         (rst_n         ),
        .bw_layer      (layer_bw      ),
        .bw_layer_valid(layer_valid[0]),
        .bw_layer_ready(layer_ready[0]),
        .bw_rsp        (bw_rsp        ),
        .bw_rsp_valid  (bw_rsp_valid  ),
        .bw_rsp_ready  (bw_rsp_ready  ),
        .fw_layer      (layer_fw      ),
        .fw_layer_valid(layer_fw_valid),
        .fw_layer_ready(layer_fw_ready),
        .fw_data       (w_fw          ),
        .fw_data_valid (w_fw_valid    ),
        .fw_data_ready (w_fw_ready    ),
        .wr            (wr            ),
        .wr_valid      (wr_valid      ),
        .wr_ready      (wr_ready      )
    );

    stream_fork #(.BRANCHES(2)) u_weight_fork (
        .clk      (clk         ),
        .rst_n    (rst_n       ),
        .in_valid (bw_rsp_valid),
        .in_ready (bw_rsp_ready),
        .out_valid(wgt_valid   ),
        .out_ready(wgt_ready   )
    );

    weight_updater u_weight_updater (
        .clk         (clk         ),
        .rst_n       (rst_n       ),
        .a           (a           ),
        .a_valid     (a_valid     ),
        .a_ready     (a_ready     ),
        .delta       (delta       ),
        .delta_valid (delta_valid ),
        .delta_ready (delta_ready ),
        .w_old       (bw_rsp      ),
        .w_old_valid (wgt_valid[0]),
        .w_old_ready (wgt_ready[0]),
        .result      (wr          ),
        .result_valid(wr_valid    ),
        .result_ready(wr_ready    ),
        .saturated   (saturated   )
    );

    ///////////////////////////////
    // outputs
    ///////////////////////////////

    assign w_bw         = bw_rsp.weights;
    assign w_bw_valid   = wgt_valid[1];
    assign wgt_ready[1] = w_bw_ready;

    // flags count only when their item is actually transferred
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            error <= 1'b0;
        end else if ((a_valid && a_ready && a_overflow) ||
                     (wr_valid && wr_ready && saturated)) begin
            error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tests/wc_props.sv */
`timescale 1ns/1ps
`default_nettype none

// handshake properties of the weight controller ports
module wc_props (
    input logic                clk,
    input logic                rst_n,
    input nn_pkg::weight_mat_t w_fw,
    input logic                w_fw_valid,
    input logic                w_fw_ready,
    input nn_pkg::weight_mat_t w_bw,
    input logic                w_bw_valid,
    input logic                w_bw_ready,
    input nn_pkg::bw_state_t   bw_state,
    input logic                bw_layer_valid,
    input logic                bw_layer_ready
);

    // an offered item stays until it is taken
    a_bw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_bw_valid && !w_bw_ready |=> w_bw_valid && $stable(w_bw))
        else $error("w_bw dropped or changed before ready");

    a_fw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_fw_valid && !w_fw_ready |=> w_fw_valid && $stable(w_fw))
        else $error("w_fw dropped or changed before ready");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> !w_bw_valid && !w_fw_valid)
        else $error("output valid high during reset");

    // an accepted backward read locks the port until its write-back
    a_interlock: assert property (@(posedge clk) disable iff (!rst_n)
        bw_layer_valid && bw_layer_ready |=>
            bw_state == nn_pkg::BW_WAIT_WRITE && !bw_layer_ready)
        else $error("backward read did not lock the port until write-back");

endmodule

bind weight_controller wc_props u_wc_props (
    .clk           (clk                           ),
    .rst_n         (rst_n                         ),
    .w_fw          (w_fw                          ),
    .w_fw_valid    (w_fw_valid                    ),
    .w_fw_ready    (w_fw_ready                    ),
    .w_bw          (w_bw                          ),
    .w_bw_valid    (w_bw_valid                    ),
    .w_bw_ready    (w_bw_ready                    ),
    .bw_state      (u_weight_store.bw_state       ),
    .bw_layer_valid(u_weight_store.bw_layer_valid ),
    .bw_layer_ready(u_weight_store.bw_layer_ready )
);

`default_nettype wire

/* tests/wc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// reference weight model and port comparisons
module wc_checker (
    input logic                clk,
    input logic                rst_n,
    input nn_pkg::layer_t      layer_bw,
    input logic                layer_bw_valid,
    input logic                layer_bw_ready,
    input nn_pkg::layer_t      layer_fw,
    input logic                layer_fw_valid,
    input logic                layer_fw_ready,
    input nn_pkg::z_vec_t      z,
    input logic                z_valid,
    input logic                z_ready,
    input nn_pkg::delta_vec_t  delta,
    input logic                delta_valid,
    input logic                delta_ready,
    input nn_pkg::weight_mat_t w_fw,
    input logic                w_fw_valid,
    input logic                w_fw_ready,
    input nn_pkg::weight_mat_t w_bw,
    input logic                w_bw_valid,
    input logic                w_bw_ready,
    input logic                error
);

    string test_name = "";
    int    error_count = 0;

    int                  model [nn_pkg::LAYER_NUM][nn_pkg::WEIGHT_CELLS];
    int                  act_cap [nn_pkg::NEURON_NUM];
    int                  upd_layer;
    logic                err_exp;
    nn_pkg::weight_mat_t exp_bw;
    int                  fw_q [$];

    function automatic nn_pkg::weight_mat_t pack_row(input int layer);
        nn_pkg::weight_mat_t m;
        m = '0;
        for (int c = 0; c < nn_pkg::WEIGHT_CELLS; c++) begin
            m[c*nn_pkg::WEIGHT_WIDTH +: nn_pkg::WEIGHT_WIDTH] = 16'(model[layer][c]);
        end
        return m;
    endfunction

    always @(posedge clk) begin
        int zs;
        int v;
        int ds;
        int diff;
        int fl;
        if (!rst_n) begin
            foreach (model[r, c]) model[r][c] = 0;
            err_exp = 1'b0;
            fw_q.delete();
        end else begin
            // activation follows the layer select seen with z
            if (z_valid && z_ready) begin
                upd_layer = int'(layer_bw);
                for (int j = 0; j < nn_pkg::NEURON_NUM; j++) begin
                    zs = int'(signed'(z[j*nn_pkg::Z_WIDTH +: nn_pkg::Z_WIDTH]));
                    if (upd_layer == 0) begin
                        v = zs & 255;
                        if (zs < 0 || zs > 255) err_exp = 1'b1;
                    end else begin
                        v = (zs >>> 1) + nn_pkg::SIGMOID_BIAS;
                        if (v < 0) v = 0;
                        if (v > 255) v = 255;
                    end
                    act_cap[j] = v;
                end
            end
            if (layer_bw_valid && layer_bw_ready) begin
                exp_bw = pack_row(int'(layer_bw));
            end
            if (delta_valid && delta_ready) begin
                for (int i = 0; i < nn_pkg::NEURON_NUM; i++) begin
                    ds = int'(signed'(delta[i*nn_pkg::DELTA_WIDTH +: nn_pkg::DELTA_WIDTH]));
                    for (int j = 0; j < nn_pkg::NEURON_NUM; j++) begin
                        diff = model[upd_layer][i*nn_pkg::NEURON_NUM+j]
                               - ((act_cap[j] * ds) >>> nn_pkg::LR_SHIFT);
                        if (diff > 32767) begin
                            diff = 32767;
                            err_exp = 1'b1;
                        end else if (diff < -32768) begin
                            diff = -32768;
                            err_exp = 1'b1;
                        end
                        model[upd_layer][i*nn_pkg::NEURON_NUM+j] = diff;
                    end
                end
            end
            if (w_bw_valid && w_bw_ready && w_bw !== exp_bw) begin
                $display("[FAIL] %s w_bw expected %h actual %h", test_name, exp_bw, w_bw);
                error_count++;
            end
            if (layer_fw_valid && layer_fw_ready) begin
                fw_q.push_back(int'(layer_fw));
            end
            if (w_fw_valid && w_fw_ready) begin
                if (fw_q.size() == 0) begin
                    $display("%s: w_fw transfer with no forward read pending", test_name);
                    error_count++;
                end else begin
                    fl = fw_q.pop_front();
                    if (w_fw !== pack_row(fl)) begin
                        $display("[FAIL] %s w_fw expected %h actual %h",
                                 test_name, pack_row(fl), w_fw);
                        error_count++;
                    end
                    if (error !== err_exp) begin
                        $display("[FAIL] %s error expected %b actual %b",
                                 test_name, err_exp, error);
                        error_count++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_weight_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_weight_controller;

    localparam int TIMEOUT = 300;

    // kind 0 backward pass, 1 forward read, 2 reset
    typedef struct {
        string name;
        int    kind;
        int    layer;
        int    z [3];
        int    d [3];
        int    stall;
    } entry_t;

    logic                clk;
    logic                rst_n;
    nn_pkg::layer_t      layer_bw;
    logic                layer_bw_valid;
    logic                layer_bw_ready;
    nn_pkg::layer_t      layer_fw;
    logic                layer_fw_valid;
    logic                layer_fw_ready;
    nn_pkg::z_vec_t      z;
    logic                z_valid;
    logic                z_ready;
    nn_pkg::delta_vec_t  delta;
    logic                delta_valid;
    logic                delta_ready;
    nn_pkg::weight_mat_t w_fw;
    logic                w_fw_valid;
    logic                w_fw_ready;
    nn_pkg::weight_mat_t w_bw;
    logic                w_bw_valid;
    logic                w_bw_ready;
    logic                error;

    entry_t stim_q [$];
    int     timeouts = 0;

    weight_controller u_weight_controller (.*);

    wc_checker u_wc_checker (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic add_entry(input string name, input int kind, input int layer,
                             input int z0, input int z1, input int z2,
                             input int d0, input int d1, input int d2, input int stall);
        entry_t e;
        e.name  = name;
        e.kind  = kind;
        e.layer = layer;
        e.z     = '{z0, z1, z2};
        e.d     = '{d0, d1, d2};
        e.stall = stall;
        stim_q.push_back(e);
    endtask

    task automatic pulse_reset();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #5 rst_n = 1'b1;
    endtask

    ////////////////////////////////
    // handshake drivers
    ////////////////////////////////

    // caller sits just after a rising edge; ready is sampled at the falling edge
    task automatic send_layer_bw(input int layer);
        int n;
        n = 0;
        layer_bw = nn_pkg::layer_t'(layer);
        layer_bw_valid = 1'b1;
        @(negedge clk);
        while (!layer_bw_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!layer_bw_ready) begin
            $display("timeout: backward layer was never accepted");
            timeouts++;
        end
        @(posedge clk);
        #5 layer_bw_valid = 1'b0;
    endtask

    task automatic send_layer_fw(input int layer);
        int n;
        n = 0;
        layer_fw = nn_pkg::layer_t'(layer);
        layer_fw_valid = 1'b1;
        @(negedge clk);
        while (!layer_fw_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!layer_fw_ready) begin
            $display("timeout: forward layer was never accepted");
            timeouts++;
        end
        @(posedge clk);
        #5 layer_fw_valid = 1'b0;
    endtask

    task automatic send_z(input entry_t e);
        int n;
        n = 0;
        for (int j = 0; j < 3; j++) z[j*nn_pkg::Z_WIDTH +: nn_pkg::Z_WIDTH] = 10'(e.z[j]);
        z_valid = 1'b1;
        @(negedge clk);
        while (!z_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!z_ready) begin
            $display("timeout: z was never accepted");
            timeouts++;
        end
        @(posedge clk);
        #5 z_valid = 1'b0;
    endtask

    task automatic send_delta(input entry_t e);
        int n;
        n = 0;
        for (int i = 0; i < 3; i++) begin
            delta[i*nn_pkg::DELTA_WIDTH +: nn_pkg::DELTA_WIDTH] = 8'(e.d[i]);
        end
        delta_valid = 1'b1;
        @(negedge clk);
        while (!delta_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!delta_ready) begin
            $display("timeout: delta was never accepted");
            timeouts++;
        end
        @(posedge clk);
        #5 delta_valid = 1'b0;
    endtask

    task automatic take_w_bw(input int stall);
        int n;
        n = 0;
        repeat (stall + int'($urandom % 4)) @(posedge clk);
        #5 w_bw_ready = 1'b1;
        @(negedge clk);
        while (!w_bw_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!w_bw_valid) begin
            $display("timeout: w_bw never became valid");
            timeouts++;
        end
        @(posedge clk);
        #5 w_bw_ready = 1'b0;
    endtask

    task automatic take_w_fw(input int stall);
        int n;
        n = 0;
        repeat (stall + int'($urandom % 4)) @(posedge clk);
        #5 w_fw_ready = 1'b1;
        @(negedge clk);
        while (!w_fw_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!w_fw_valid) begin
            $display("timeout: w_fw never became valid");
            timeouts++;
        end
        @(posedge clk);
        #5 w_fw_ready = 1'b0;
    endtask

    // the update is finished once the store leaves its write interlock
    task automatic wait_store_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (u_weight_controller.u_weight_store.bw_state != nn_pkg::BW_IDLE &&
               n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (u_weight_controller.u_weight_store.bw_state != nn_pkg::BW_IDLE) begin
            $display("timeout: weight write-back never completed");
            timeouts++;
        end
        @(posedge clk);
        #5;
    endtask

    initial begin
        void'($urandom(32'hb2fd98b0));
        rst_n          = 1'b0;
        layer_bw       = '0;
        layer_bw_valid = 1'b0;
        layer_fw       = '0;
        layer_fw_valid = 1'b0;
        z              = '0;
        z_valid        = 1'b0;
        delta          = '0;
        delta_valid    = 1'b0;
        w_fw_ready     = 1'b0;
        w_bw_ready     = 1'b0;

        for (int l = 0; l < 4; l++) add_entry($sformatf("reset_read_l%0d", l), 1, l,
                                               0, 0, 0, 0, 0, 0, 0);
        add_entry("bw_l2_sigmoid", 0, 2, 10, -20, 100, 5, -3, 7, 1);
        add_entry("bw_l2_sigmoid", 1, 2, 0, 0, 0, 0, 0, 0, 0);
        add_entry("bw_l0_trunc", 0, 0, 5, 20, 200, 2, 1, -1, 0);
        add_entry("bw_l0_trunc", 1, 0, 0, 0, 0, 0, 0, 0, 0);
        add_entry("bw_l0_overflow", 0, 0, 300, -4, 7, 1, 1, 1, 0);
        add_entry("bw_l0_overflow", 1, 0, 0, 0, 0, 0, 0, 0, 2);
        // sticky error cleared so the later sources are seen on their own
        add_entry("mid_reset", 2, 0, 0, 0, 0, 0, 0, 0, 0);
        add_entry("back_to_back_l1", 0, 1, 60, -60, 0, -50, 40, 9, 0);
        add_entry("back_to_back_l1", 0, 1, 200, 30, -100, 20, -70, 3, 0);
        add_entry("back_to_back_l1", 1, 1, 0, 0, 0, 0, 0, 0, 0);
        add_entry("random_stall", 0, 2, -300, 400, 1, -9, 11, 100, 6);
        add_entry("random_stall", 1, 2, 0, 0, 0, 0, 0, 0, 7);
        // each pass subtracts 2024 until the cells clamp
        for (int k = 0; k < 17; k++) add_entry("saturate_l3", 0, 3, 500, 500, 500,
                                                127, 127, 127, 0);
        add_entry("saturate_l3", 1, 3, 0, 0, 0, 0, 0, 0, 0);

        pulse_reset();

        foreach (stim_q[k]) begin
            u_wc_checker.test_name = stim_q[k].name;
            if (stim_q[k].kind == 2) begin
                wait_store_idle();
                pulse_reset();
            end else if (stim_q[k].kind == 1) begin
                wait_store_idle();
                fork
                    send_layer_fw(stim_q[k].layer);
                    take_w_fw(stim_q[k].stall);
                join
            end else begin
                fork
                    send_layer_bw(stim_q[k].layer);
                    send_z(stim_q[k]);
                    send_delta(stim_q[k]);
                    take_w_bw(stim_q[k].stall);
                join
            end
        end
        wait_store_idle();

        $display("errors: %0d mismatches, %0d timeouts", u_wc_checker.error_count, timeouts);
        if (u_wc_checker.error_count == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
common/nn_pkg.sv
hw/stream_fork.sv
hw/activation_path.sv
weight_update/weight_store.sv
weight_update/weight_updater.sv
hw/weight_controller.sv
tests/wc_props.sv
tests/wc_checker.sv
tests/tb_weight_controller.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_weight_controller
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf $(BUILD_DIR)
